/* verilog/MipsPkg.sv */
package MipsPkg;

    // operations carried out by the execute stage.
    typedef enum logic [4:0] {
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluMult,
        aluMultu,
        aluDiv,
        aluDivu,
        aluMthi,
        aluMtlo,
        aluMfhi,
        aluMflo,
        aluLink
    } aluOpE;

    typedef enum logic [2:0] {
        memNone,
        memLoadByte,
        memLoadHalf,
        memLoadWord,
        memStoreByte,
        memStoreHalf,
        memStoreWord
    } memOpE;

    typedef enum logic [1:0] {
        excNone,
        excOverflow,
        excAddrLoad,
        excAddrStore
    } excE;

    // decoded instruction waiting in the ID/EX slot.
    typedef struct packed {
        aluOpE       aluOp;
        logic        useImm;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
        logic [31:0] pc;
        memOpE       memOp;
        logic [4:0]  writeReg;
        logic        writeEn;
    } idExT;

    // record handed on to the memory stage.
    typedef struct packed {
        logic [31:0] result;
        logic [31:0] storeData;
        memOpE       memOp;
        logic [4:0]  writeReg;
        logic        writeEn;
        excE         exc;
    } exMemT;

endpackage

/* verilog/AluIf.sv */
`timescale 1ns/1ps

interface AluIf;
    logic [31:0]    srcA;
    logic [31:0]    srcB;
    MipsPkg::aluOpE aluOp;
    // shift amount taken from imm[10:6].
    logic [4:0]     shamt;

    modport source (
        output srcA,
        output srcB,
        output aluOp,
        output shamt
    );

    modport sink (
        input srcA,
        input srcB,
        input aluOp,
        input shamt
    );
endinterface

/* verilog/PipeReg.sv */
`timescale 1ns/1ps

module PipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    // an empty slot, or one being drained this cycle, can take a new item.
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // payload only moves on an accepted transfer.
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

/* verilog/OperandSelect.sv */
`timescale 1ns/1ps

module OperandSelect (
    input  logic [31:0]    rsData,
    input  logic [31:0]    rtData,
    input  logic [31:0]    imm,
    input  logic [31:0]    pc,
    input  MipsPkg::aluOpE aluOp,
    input  logic           useImm,
    AluIf.source           alu
);

    logic isLink;

    assign isLink = (aluOp == MipsPkg::aluLink);

    // return address skips the delay slot.
    assign alu.srcA = isLink ? pc + 32'd8 : rsData;

    assign alu.srcB = useImm ? imm : rtData;

    assign alu.shamt = imm[10:6];
    assign alu.aluOp = aluOp;

endmodule

/* verilog/Alu.sv */
`timescale 1ns/1ps

module Alu (
    AluIf.sink          alu,
    input  logic [31:0] hi,
    input  logic [31:0] lo,
    output logic [31:0] result,
    output logic [63:0] product,
    output logic        overflow
);

    logic [31:0]        sum;
    logic [31:0]        diff;
    logic               sumOvf;
    logic               diffOvf;
    logic signed [63:0] signedProd;
    logic [63:0]        unsignedProd;
    logic               divByZero;

    assign sum  = alu.srcA + alu.srcB;
    assign diff = alu.srcA - alu.srcB;

    // signed overflow when the operand signs rule out the result sign.
    assign sumOvf  = (alu.srcA[31] == alu.srcB[31]) && (sum[31] != alu.srcA[31]);
    assign diffOvf = (alu.srcA[31] != alu.srcB[31]) && (diff[31] != alu.srcA[31]);

    assign signedProd = $signed({{32{alu.srcA[31]}}, alu.srcA})
                      * $signed({{32{alu.srcB[31]}}, alu.srcB});
    assign unsignedProd = {32'd0, alu.srcA} * {32'd0, alu.srcB};

    assign divByZero = (alu.srcB == 32'd0);

    always_comb begin
        case (alu.aluOp)
            MipsPkg::aluAdd, MipsPkg::aluAddu: result = sum;
            MipsPkg::aluSub, MipsPkg::aluSubu: result = diff;
            MipsPkg::aluAnd:   result = alu.srcA & alu.srcB;
            MipsPkg::aluOr:    result = alu.srcA | alu.srcB;
            MipsPkg::aluXor:   result = alu.srcA ^ alu.srcB;
            MipsPkg::aluNor:   result = ~(alu.srcA | alu.srcB);
            MipsPkg::aluSlt:   result = {31'd0, $signed(alu.srcA) < $signed(alu.srcB)};
            MipsPkg::aluSltu:  result = {31'd0, alu.srcA < alu.srcB};
            MipsPkg::aluSll:   result = alu.srcB << alu.shamt;
            MipsPkg::aluSrl:   result = alu.srcB >> alu.shamt;
            MipsPkg::aluSra:   result = $signed(alu.srcB) >>> alu.shamt;
            MipsPkg::aluLui:   result = {alu.srcB[15:0], 16'd0};
            MipsPkg::aluMfhi:  result = hi;
            MipsPkg::aluMflo:  result = lo;
            MipsPkg::aluLink, MipsPkg::aluMthi, MipsPkg::aluMtlo: result = alu.srcA;
            default:           result = 32'd0;
        endcase
    end

    // high word goes to HI, low word to LO.
    always_comb begin
        case (alu.aluOp)
            MipsPkg::aluMult:  product = signedProd;
            MipsPkg::aluMultu: product = unsignedProd;
            MipsPkg::aluDiv: begin
                if (divByZero) begin
                    product = 64'd0;
                end else begin
                    product = {$signed(alu.srcA) % $signed(alu.srcB),
                               $signed(alu.srcA) / $signed(alu.srcB)};
                end
            end
            MipsPkg::aluDivu: begin
                if (divByZero) begin
                    product = 64'd0;
                end else begin
                    product = {alu.srcA % alu.srcB, alu.srcA / alu.srcB};
                end
            end
            default: product = 64'd0;
        endcase
    end

    assign overflow = ((alu.aluOp == MipsPkg::aluAdd) && sumOvf)
                   || ((alu.aluOp == MipsPkg::aluSub) && diffOvf);

endmodule

/* verilog/HiLoUnit.sv */
`timescale 1ns/1ps

module HiLoUnit (
    input  logic        clk,
    input  logic        rstN,
    AluIf.sink          alu,
    input  logic [63:0] product,
    input  logic        commit,
    input  logic        squash,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic update;

    // only an instruction leaving execute without an exception writes.
    assign update = commit && !squash;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= 32'd0;
            lo <= 32'd0;
        end else if (update) begin
            case (alu.aluOp)
                MipsPkg::aluMult,
                MipsPkg::aluMultu,
                MipsPkg::aluDiv,
                MipsPkg::aluDivu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                MipsPkg::aluMthi: begin
                    hi <= alu.srcA;
                end
                MipsPkg::aluMtlo: begin
                    lo <= alu.srcA;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* verilog/Execute.sv */
`timescale 1ns/1ps

module Execute (
    input  logic          clk,
    input  logic          rstN,
    input  MipsPkg::idExT idEx,
    input  logic          advance,
    output MipsPkg::exMemT exMem
);

    logic [31:0]  result;
    logic [63:0]  product;
    logic         overflow;
    logic [31:0]  hi;
    logic [31:0]  lo;
    logic         isLoad;
    logic         isStore;
    logic         misaligned;
    MipsPkg::excE exc;

    AluIf alu ();

    OperandSelect uOperandSelect (
        .rsData (idEx.rsData),
        .rtData (idEx.rtData),
        .imm    (idEx.imm),
        .pc     (idEx.pc),
        .aluOp  (idEx.aluOp),
        .useImm (idEx.useImm),
        .alu    (alu)
    );

    Alu uAlu (
        .alu      (alu),
        .hi       (hi),
        .lo       (lo),
        .result   (result),
        .product  (product),
        .overflow (overflow)
    );

    HiLoUnit uHiLoUnit (
        .clk     (clk),
        .rstN    (rstN),
        .alu     (alu),
        .product (product),
        .commit  (advance),
        .squash  (exc != MipsPkg::excNone),
        .hi      (hi),
        .lo      (lo)
    );

    assign isLoad  = idEx.memOp inside {MipsPkg::memLoadByte, MipsPkg::memLoadHalf,
                                        MipsPkg::memLoadWord};
    assign isStore = idEx.memOp inside {MipsPkg::memStoreByte, MipsPkg::memStoreHalf,
                                        MipsPkg::memStoreWord};

    // byte accesses never fault.
    always_comb begin
        case (idEx.memOp)
            MipsPkg::memLoadHalf, MipsPkg::memStoreHalf: misaligned = result[0];
            MipsPkg::memLoadWord, MipsPkg::memStoreWord: misaligned = |result[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (overflow) begin
            exc = MipsPkg::excOverflow;
        end else if (misaligned && isStore) begin
            exc = MipsPkg::excAddrStore;
        end else if (misaligned && isLoad) begin
            exc = MipsPkg::excAddrLoad;
        end else begin
            exc = MipsPkg::excNone;
        end
    end

    always_comb begin
        exMem.result    = result;
        exMem.storeData = idEx.rtData;
        exMem.memOp     = idEx.memOp;
        exMem.writeReg  = idEx.writeReg;
        exMem.writeEn   = idEx.writeEn && (exc == MipsPkg::excNone);
        exMem.exc       = exc;
    end

endmodule

/* verilog/ExecuteTop.sv */
`timescale 1ns/1ps

module ExecuteTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    output logic            inReady,
    input  MipsPkg::aluOpE  aluOp,
    input  logic            useImm,
    input  logic [31:0]     rsData,
    input  logic [31:0]     rtData,
    input  logic [31:0]     imm,
    input  logic [31:0]     pc,
    input  MipsPkg::memOpE  memOp,
    input  logic [4:0]      writeReg,
    input  logic            writeEn,
    output logic            outValid,
    input  logic            outReady,
    output logic [31:0]     outResult,
    output logic [31:0]     outStoreData,
    output MipsPkg::memOpE  outMemOp,
    output logic [4:0]      outWriteReg,
    output logic            outWriteEn,
    output MipsPkg::excE    outExc
);

    MipsPkg::idExT  idExIn;
    MipsPkg::idExT  idExOut;
    MipsPkg::exMemT exMemIn;
    MipsPkg::exMemT exMemOut;
    logic           idExValid;
    logic           exMemInReady;
    logic           advance;

    assign idExIn = '{aluOp: aluOp, useImm: useImm, rsData: rsData, rtData: rtData,
                      imm: imm, pc: pc, memOp: memOp, writeReg: writeReg, writeEn: writeEn};

    // the execute item moves on when EX/MEM takes it.
    assign advance = idExValid && exMemInReady;

    PipeReg #(.payloadT(MipsPkg::idExT)) uIdEx (
        .clk (clk), .rstN (rstN),
        .inValid (inValid), .inData (idExIn), .inReady (inReady),
        .outValid (idExValid), .outData (idExOut), .outReady (exMemInReady)
    );

    Execute uExecute (
        .clk (clk), .rstN (rstN), .idEx (idExOut), .advance (advance), .exMem (exMemIn)
    );

    PipeReg #(.payloadT(MipsPkg::exMemT)) uExMem (
        .clk (clk), .rstN (rstN),
        .inValid (idExValid), .inData (exMemIn), .inReady (exMemInReady),
        .outValid (outValid), .outData (exMemOut), .outReady (outReady)
    );

    assign outResult    = exMemOut.result;
    assign outStoreData = exMemOut.storeData;
    assign outMemOp     = exMemOut.memOp;
    assign outWriteReg  = exMemOut.writeReg;
    assign outWriteEn   = exMemOut.writeEn;
    assign outExc       = exMemOut.exc;

endmodule

/* test/Execute_assertions.sv */
`timescale 1ns/1ps

module ExecuteChecks (
    input logic           clk,
    input logic           rstN,
    input logic           outValid,
    input logic           outReady,
    input logic [31:0]    outResult,
    input logic [31:0]    outStoreData,
    input MipsPkg::memOpE outMemOp,
    input logic [4:0]     outWriteReg,
    input logic           outWriteEn,
    input MipsPkg::excE   outExc
);

    int failCount = 0;

    // a stalled output keeps its item.
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid
            && $stable({outResult, outStoreData, outMemOp, outWriteReg, outWriteEn, outExc}))
    else begin
        failCount++;
        $error("output item changed while stalled");
    end

    noWriteOnException: assert property (@(posedge clk) disable iff (!rstN)
        outValid && (outExc != MipsPkg::excNone) |-> !outWriteEn)
    else begin
        failCount++;
        $error("write enable set on an excepting instruction");
    end

    quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else begin
        failCount++;
        $error("output valid during reset");
    end

endmodule

bind ExecuteTop ExecuteChecks outputChecks (
    .clk (clk), .rstN (rstN), .outValid (outValid), .outReady (outReady),
    .outResult (outResult), .outStoreData (outStoreData), .outMemOp (outMemOp),
    .outWriteReg (outWriteReg), .outWriteEn (outWriteEn), .outExc (outExc)
);

/* test/ExecuteTb.sv */
`timescale 1ns/1ps

module ExecuteTb;

    localparam int waitLimit = 50;

    logic           clk;
    logic           rstN;
    logic           inValid;
    logic           inReady;
    MipsPkg::aluOpE aluOp;
    logic           useImm;
    logic [31:0]    rsData;
    logic [31:0]    rtData;
    logic [31:0]    imm;
    logic [31:0]    pc;
    MipsPkg::memOpE memOp;
    logic [4:0]     writeReg;
    logic           writeEn;
    logic           outValid;
    logic           outReady;
    logic [31:0]    outResult;
    logic [31:0]    outStoreData;
    MipsPkg::memOpE outMemOp;
    logic [4:0]     outWriteReg;
    logic           outWriteEn;
    MipsPkg::excE   outExc;

    // expected records in issue order.
    MipsPkg::exMemT expQ[$];
    bit             resultQ[$];
    logic [31:0]    modelHi;
    logic [31:0]    modelLo;
    logic [4:0]     nextReg;
    integer         seed;
    int             itemCount;
    int             errors;

    ExecuteTop UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s at %0t", why, $time);
        $display("%0d items checked, %0d errors", itemCount, errors);
        $display("** FAIL **");
        $finish;
    endtask

    // reference model with its own HI/LO copy.
    task automatic predict(input MipsPkg::aluOpE op, input logic useI, input logic [31:0] rs,
                           input logic [31:0] rt, input logic [31:0] im, input logic [31:0] pcv,
                           input MipsPkg::memOpE mop, input logic [4:0] wr, input logic wen);
        MipsPkg::exMemT want;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [32:0]    wide;
        logic [63:0]    prod;
        logic [4:0]     sh;
        bit             defined;
        bit             ovf;
        bit             odd;
        a = (op == MipsPkg::aluLink) ? pcv + 32'd8 : rs;
        b = useI ? im : rt;
        sh = im[10:6];
        defined = 1'b1;
        ovf = 1'b0;
        prod = 64'd0;
        want.result = 32'd0;
        case (op)
            MipsPkg::aluAdd, MipsPkg::aluAddu: begin
                wide = {a[31], a} + {b[31], b};
                want.result = wide[31:0];
                ovf = (op == MipsPkg::aluAdd) && (wide[32] != wide[31]);
            end
            MipsPkg::aluSub, MipsPkg::aluSubu: begin
                wide = {a[31], a} - {b[31], b};
                want.result = wide[31:0];
                ovf = (op == MipsPkg::aluSub) && (wide[32] != wide[31]);
            end
            MipsPkg::aluAnd:  want.result = a & b;
            MipsPkg::aluOr:   want.result = a | b;
            MipsPkg::aluXor:  want.result = a ^ b;
            MipsPkg::aluNor:  want.result = ~(a | b);
            MipsPkg::aluSlt:  want.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            MipsPkg::aluSltu: want.result = (a < b) ? 32'd1 : 32'd0;
            MipsPkg::aluSll:  want.result = b << sh;
            MipsPkg::aluSrl:  want.result = b >> sh;
            MipsPkg::aluSra:  want.result = (b >> sh) | (~(32'hffff_ffff >> sh) & {32{b[31]}});
            MipsPkg::aluLui:  want.result = {b[15:0], 16'h0000};
            MipsPkg::aluMfhi: want.result = modelHi;
            MipsPkg::aluMflo: want.result = modelLo;
            MipsPkg::aluLink: want.result = a;
            MipsPkg::aluMult: prod = longint'(int'(a)) * longint'(int'(b));
            MipsPkg::aluMultu: prod = {32'd0, a} * {32'd0, b};
            MipsPkg::aluDiv: begin
                if (b != 32'd0) begin
                    prod[31:0] = int'(a) / int'(b);
                    prod[63:32] = int'(a) % int'(b);
                end
            end
            MipsPkg::aluDivu: begin
                if (b != 32'd0) begin
                    prod[31:0] = a / b;
                    prod[63:32] = a % b;
                end
            end
            default: want.result = 32'd0;
        endcase
        // mult, divide and HI/LO writes leave the result undefined.
        if (op inside {MipsPkg::aluMult, MipsPkg::aluMultu, MipsPkg::aluDiv, MipsPkg::aluDivu,
                       MipsPkg::aluMthi, MipsPkg::aluMtlo}) begin
            defined = 1'b0;
        end
        case (mop)
            MipsPkg::memLoadHalf, MipsPkg::memStoreHalf: odd = want.result[0];
            MipsPkg::memLoadWord, MipsPkg::memStoreWord: odd = (want.result[1:0] != 2'b00);
            default: odd = 1'b0;
        endcase
        if (ovf) begin
            want.exc = MipsPkg::excOverflow;
        end else if (odd && (mop inside {MipsPkg::memStoreHalf, MipsPkg::memStoreWord})) begin
            want.exc = MipsPkg::excAddrStore;
        end else if (odd) begin
            want.exc = MipsPkg::excAddrLoad;
        end else begin
            want.exc = MipsPkg::excNone;
        end
        want.storeData = rt;
        want.memOp = mop;
        want.writeReg = wr;
        want.writeEn = wen && (want.exc == MipsPkg::excNone);
        if (want.exc == MipsPkg::excNone) begin
            if (op inside {MipsPkg::aluMult, MipsPkg::aluMultu, MipsPkg::aluDiv,
                           MipsPkg::aluDivu}) begin
                modelHi = prod[63:32];
                modelLo = prod[31:0];
            end else if (op == MipsPkg::aluMthi) begin
                modelHi = a;
            end else if (op == MipsPkg::aluMtlo) begin
                modelLo = a;
            end
        end
        expQ.push_back(want);
        resultQ.push_back(defined);
    endtask

    task automatic send(input MipsPkg::aluOpE op, input logic useI, input logic [31:0] rs,
                        input logic [31:0] rt, input logic [31:0] im, input logic [31:0] pcv,
                        input MipsPkg::memOpE mop);
        int   waited;
        logic we;
        // every fourth item goes without a register write.
        we = (nextReg[1:0] != 2'b11);
        predict(op, useI, rs, rt, im, pcv, mop, nextReg, we);
        aluOp = op;
        useImm = useI;
        rsData = rs;
        rtData = rt;
        imm = im;
        pc = pcv;
        memOp = mop;
        writeReg = nextReg;
        writeEn = we;
        inValid = 1'b1;
        nextReg = nextReg + 5'd1;
        waited = 0;
        @(negedge clk);
        while (!inReady && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!inReady) begin
            abortRun("timeout waiting for inReady");
        end else begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < waitLimit) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            abortRun("timeout waiting for outValid");
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        MipsPkg::exMemT want;
        MipsPkg::exMemT got;
        if (rstN && outValid && outReady) begin
            assert (expQ.size() != 0) else begin
                errors++;
                $display("an output appeared with no item pending at %0t", $time);
            end
            if (expQ.size() != 0) begin
                want = expQ.pop_front();
                got = '{outResult, outStoreData, outMemOp, outWriteReg, outWriteEn, outExc};
                if (!resultQ.pop_front()) begin
                    want.result = 32'd0;
                    got.result = 32'd0;
                end
                itemCount++;
                assert (got == want) else begin
                    errors++;
                    $display("FAILED at %0t: got %h, expected %h", $time, got, want);
                end
            end
        end
    end

    task automatic aluOperations;
        logic [31:0] edges[4];
        edges = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        for (int k = 0; k <= 13; k++) begin
            for (int n = 0; n < 6; n++) begin
                send(MipsPkg::aluOpE'(5'(k)), n[0], $random(seed), $random(seed),
                     $random(seed), 32'h0040_0000, MipsPkg::memNone);
            end
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send(MipsPkg::aluOpE'(5'(k)), 1'b0, edges[i], edges[j], $random(seed),
                         32'h0040_0000, MipsPkg::memNone);
                end
            end
        end
        drain;
    endtask

    task automatic overflowCases;
        send(MipsPkg::aluAdd, 1'b0, 32'h7fff_ffff, 32'd1, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluAddu, 1'b0, 32'h7fff_ffff, 32'd1, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluAdd, 1'b1, 32'h8000_0000, 32'd0, 32'hffff_ffff, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluSub, 1'b0, 32'h8000_0000, 32'd1, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluSubu, 1'b0, 32'h8000_0000, 32'd1, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluSub, 1'b0, 32'h7fff_ffff, 32'hffff_ffff, 32'd0, 32'd0, MipsPkg::memNone);
        drain;
    endtask

    task automatic hiLoSequence;
        logic [31:0] b;
        for (int k = 14; k <= 17; k++) begin
            for (int n = 0; n < 3; n++) begin
                b = (n == 2) ? 32'd0 : $random(seed);
                send(MipsPkg::aluOpE'(5'(k)), 1'b0, $random(seed), b, 32'd0, 32'd0,
                     MipsPkg::memNone);
                send(MipsPkg::aluMfhi, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
                send(MipsPkg::aluMflo, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
            end
        end
        send(MipsPkg::aluMthi, 1'b0, 32'hcafe_0001, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluMtlo, 1'b0, 32'h1234_5678, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluMfhi, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluMflo, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        // an overflowing add must leave HI and LO alone.
        send(MipsPkg::aluAdd, 1'b0, 32'h7fff_ffff, 32'h7fff_ffff, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluMfhi, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        send(MipsPkg::aluMflo, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, MipsPkg::memNone);
        drain;
    endtask

    task automatic memoryAlignment;
        logic [31:0] base;
        for (int m = 1; m <= 6; m++) begin
            for (int off = 0; off < 4; off++) begin
                base = $random(seed);
                base[1:0] = 2'b00;
                send(MipsPkg::aluAddu, 1'b1, base, $random(seed), 32'(off), 32'd0,
                     MipsPkg::memOpE'(3'(m)));
            end
        end
        drain;
    endtask

    task automatic linkResult;
        for (int n = 0; n < 4; n++) begin
            send(MipsPkg::aluLink, 1'b0, $random(seed), $random(seed), 32'd0, $random(seed),
                 MipsPkg::memNone);
        end
        drain;
    endtask

    task automatic backPressureBurst;
        outReady = 1'b0;
        fork
            for (int n = 0; n < 8; n++) begin
                send(MipsPkg::aluXor, 1'b0, $random(seed), $random(seed), 32'd0, 32'd0,
                     MipsPkg::memNone);
            end
            begin
                repeat (6) @(negedge clk);
                assert (!inReady && outValid) else begin
                    errors++;
                    $display("FAILED at %0t: inReady %b, outValid %b with both slots full",
                             $time, inReady, outValid);
                end
                @(posedge clk);
                #1;
                outReady = 1'b1;
            end
        join
        drain;
    endtask

    initial begin
        seed = 31;
        itemCount = 0;
        errors = 0;
        modelHi = 32'd0;
        modelLo = 32'd0;
        nextReg = 5'd0;
        rstN = 1'b0;
        inValid = 1'b0;
        aluOp = MipsPkg::aluAdd;
        useImm = 1'b0;
        rsData = 32'd0;
        rtData = 32'd0;
        imm = 32'd0;
        pc = 32'd0;
        memOp = MipsPkg::memNone;
        writeReg = 5'd0;
        writeEn = 1'b0;
        outReady = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        assert (inReady && !outValid) else begin
            errors++;
            $display("FAILED at %0t: inReady %b, outValid %b after reset",
                     $time, inReady, outValid);
        end
        aluOperations;
        overflowCases;
        hiLoSequence;
        memoryAlignment;
        linkResult;
        backPressureBurst;
        $display("%0d items checked, %0d errors, %0d assertion failures",
                 itemCount, errors, UUT.outputChecks.failCount);
        if (errors == 0 && UUT.outputChecks.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/MipsPkg.sv
verilog/AluIf.sv
verilog/PipeReg.sv
verilog/OperandSelect.sv
verilog/Alu.sv
verilog/HiLoUnit.sv
verilog/Execute.sv
verilog/ExecuteTop.sv
test/Execute_assertions.sv
test/ExecuteTb.sv

/* Makefile */
TOOL     = verilator
TOP      = ExecuteTb
FILELIST = tb.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
SIMARGS  = +verilator+error+limit+100
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
